// ==== cpu_pkg.sv ====
package cpu_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int data_width    = 32;
  localparam int addr_width    = 16;
  localparam int inst_width    = 32;
  localparam int num_regs_log2 = 5;
  localparam int imm_width     = 16;

  // instruction fields, opcode on top
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;
  localparam int imm_msb    = 15;
  localparam int imm_lsb    = 0;

  ////////////////////
  // encodings
  ////////////////////
  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_slt  = 6'd5,
    op_addi = 6'd6,
    op_lw   = 6'd7,
    op_sw   = 6'd8,
    op_beq  = 6'd9
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_read  = 2'd1,
    mem_write = 2'd2
  } mem_op_e;

  typedef enum logic [1:0] {
    fwd_reg    = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_e;

  ////////////////////
  // pipeline records
  ////////////////////
  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;
    mem_op_e mem_op;
    alu_op_e alu_op;
    logic    alu_src;
    logic    reg_dst;
    logic    branch;
  } ctrl_t;

  typedef struct packed {
    logic                     valid;
    ctrl_t                    ctrl;
    logic [num_regs_log2-1:0] rs;
    logic [num_regs_log2-1:0] rt;
    logic [num_regs_log2-1:0] rd;
    logic [data_width-1:0]    read_data_a;
    logic [data_width-1:0]    read_data_b;
    logic [imm_width-1:0]     imm;
  } id_ex_t;

  typedef struct packed {
    logic                     valid;
    logic                     reg_write;
    logic                     mem_to_reg;
    mem_op_e                  mem_op;
    logic [num_regs_log2-1:0] dst;
    logic [data_width-1:0]    alu_result;
    logic [data_width-1:0]    store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                     valid;
    logic                     reg_write;
    logic                     mem_to_reg;
    logic [num_regs_log2-1:0] dst;
    logic [data_width-1:0]    alu_result;
    logic [data_width-1:0]    read_data;
  } mem_wb_t;

endpackage

// ==== program_counter.sv ====
`timescale 1ns/100ps

module program_counter (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           branch_taken,
  input  logic [cpu_pkg::addr_width-1:0] branch_target,
  output logic [cpu_pkg::addr_width-1:0] pc
);

  // taken branch beats a load-use stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      // word addressed, so one step per instruction
      pc <= pc + 1'b1;
    end
  end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/100ps

module control_unit (
  input  cpu_pkg::opcode_e opcode,
  output cpu_pkg::ctrl_t   ctrl
);

  import cpu_pkg::*;

  always_comb begin
    // nop defaults, also used for unknown opcodes
    ctrl.reg_write  = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.mem_op     = mem_none;
    ctrl.alu_op     = alu_add;
    ctrl.alu_src    = 1'b0;
    ctrl.reg_dst    = 1'b0;
    ctrl.branch     = 1'b0;

    case (opcode)
      op_add, op_sub, op_and, op_or, op_slt: begin
        ctrl.reg_write = 1'b1;
        ctrl.reg_dst   = 1'b1;
        case (opcode)
          op_sub:  ctrl.alu_op = alu_sub;
          op_and:  ctrl.alu_op = alu_and;
          op_or:   ctrl.alu_op = alu_or;
          op_slt:  ctrl.alu_op = alu_slt;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_addi: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      op_lw: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.mem_op     = mem_read;
        ctrl.alu_src    = 1'b1;
      end
      op_sw: begin
        ctrl.mem_op  = mem_write;
        ctrl.alu_src = 1'b1;
      end
      op_beq: begin
        // compare rs with rt, target comes from the immediate
        ctrl.alu_op = alu_sub;
        ctrl.branch = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/100ps

module register_file (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [cpu_pkg::num_regs_log2-1:0] read_addr_a,
  input  logic [cpu_pkg::num_regs_log2-1:0] read_addr_b,
  output logic [cpu_pkg::data_width-1:0]    read_data_a,
  output logic [cpu_pkg::data_width-1:0]    read_data_b,
  input  logic                              write_en,
  input  logic [cpu_pkg::num_regs_log2-1:0] write_addr,
  input  logic [cpu_pkg::data_width-1:0]    write_data
);

  import cpu_pkg::*;

  logic [data_width-1:0] regs [2**num_regs_log2];
  logic                  write_live;

  // r0 never takes a write
  assign write_live = write_en && (write_addr != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**num_regs_log2; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[write_addr] <= write_data;
    end
  end

  // write-back in the same cycle is seen by decode
  assign read_data_a = (write_live && write_addr == read_addr_a) ? write_data : regs[read_addr_a];
  assign read_data_b = (write_live && write_addr == read_addr_b) ? write_data : regs[read_addr_b];

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
  input  logic [cpu_pkg::num_regs_log2-1:0] decode_rs,
  input  logic [cpu_pkg::num_regs_log2-1:0] decode_rt,
  input  cpu_pkg::id_ex_t                   id_ex,
  input  cpu_pkg::ex_mem_t                  ex_mem,
  input  cpu_pkg::mem_wb_t                  mem_wb,
  input  logic                              branch_taken,
  output logic                              stall,
  output logic                              flush,
  output cpu_pkg::fwd_sel_e                 fwd_a,
  output cpu_pkg::fwd_sel_e                 fwd_b
);

  import cpu_pkg::*;

  // youngest producer wins
  function automatic fwd_sel_e pick_source(input logic [num_regs_log2-1:0] src,
                                           input ex_mem_t em,
                                           input mem_wb_t mw);
    if (em.valid && em.reg_write && em.dst != '0 && em.dst == src) begin
      return fwd_ex_mem;
    end
    if (mw.valid && mw.reg_write && mw.dst != '0 && mw.dst == src) begin
      return fwd_mem_wb;
    end
    return fwd_reg;
  endfunction

  // load in execute feeding the instruction in decode
  assign stall = id_ex.valid && (id_ex.ctrl.mem_op == mem_read) && (id_ex.rt != '0) &&
                 ((id_ex.rt == decode_rs) || (id_ex.rt == decode_rt));

  // branch resolves in execute, two younger slots are dead
  assign flush = branch_taken;

  assign fwd_a = pick_source(id_ex.rs, ex_mem, mem_wb);
  assign fwd_b = pick_source(id_ex.rt, ex_mem, mem_wb);

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::alu_op_e                alu_op,
  input  logic [cpu_pkg::data_width-1:0]  operand_a,
  input  logic [cpu_pkg::data_width-1:0]  operand_b,
  output logic [cpu_pkg::data_width-1:0]  result,
  output logic                            zero,
  output logic                            less,
  output logic                            greater
);

  import cpu_pkg::*;

  // flags come straight from a signed compare
  assign zero    = (operand_a == operand_b);
  assign less    = ($signed(operand_a) < $signed(operand_b));
  assign greater = ($signed(operand_a) > $signed(operand_b));

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = operand_a + operand_b;
      end
      alu_sub: begin
        result = operand_a - operand_b;
      end
      alu_and: begin
        result = operand_a & operand_b;
      end
      alu_or: begin
        result = operand_a | operand_b;
      end
      alu_slt: begin
        result = {{(data_width-1){1'b0}}, less};
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== processor.sv ====
`timescale 1ns/100ps

module processor (
  input  logic                           clk,
  input  logic                           reset,
  output logic [cpu_pkg::addr_width-1:0] pc,
  input  logic [cpu_pkg::inst_width-1:0] instruction,
  output logic [cpu_pkg::addr_width-1:0] address_out,
  output logic [cpu_pkg::data_width-1:0] write_data_out,
  output cpu_pkg::mem_op_e               mem_op_out,
  input  logic [cpu_pkg::data_width-1:0] read_data
);

  import cpu_pkg::*;

  logic [inst_width-1:0]    if_id_inst;
  logic                     if_id_valid;
  opcode_e                  dec_opcode;
  logic [num_regs_log2-1:0] dec_rs;
  logic [num_regs_log2-1:0] dec_rt;
  logic [num_regs_log2-1:0] dec_rd;
  ctrl_t                    dec_ctrl;
  logic [data_width-1:0]    reg_data_a;
  logic [data_width-1:0]    reg_data_b;
  id_ex_t                   id_ex, id_ex_next;
  ex_mem_t                  ex_mem, ex_mem_next;
  mem_wb_t                  mem_wb, mem_wb_next;
  logic                     stall;
  logic                     flush;
  fwd_sel_e                 fwd_a;
  fwd_sel_e                 fwd_b;
  logic [data_width-1:0]    ex_operand_a;
  logic [data_width-1:0]    ex_rt_value;
  logic [data_width-1:0]    ex_operand_b;
  logic [data_width-1:0]    alu_result;
  logic                     alu_zero;
  logic                     branch_taken;
  logic [data_width-1:0]    wb_data;

  ////////////////////
  // fetch
  ////////////////////
  program_counter i_program_counter (
    .clk           (clk),
    .reset         (reset),
    .stall         (stall),
    .branch_taken  (branch_taken),
    .branch_target (id_ex.imm[addr_width-1:0]),
    .pc            (pc)
  );

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_id_inst <= instruction;
    end
    if (reset || flush) begin
      if_id_valid <= 1'b0;
    end else if (!stall) begin
      if_id_valid <= 1'b1;
    end
  end

  ////////////////////
  // decode
  ////////////////////
  assign dec_opcode = opcode_e'(if_id_inst[opcode_msb:opcode_lsb]);
  assign dec_rs     = if_id_inst[rs_msb:rs_lsb];
  assign dec_rt     = if_id_inst[rt_msb:rt_lsb];
  assign dec_rd     = if_id_inst[rd_msb:rd_lsb];

  control_unit i_control_unit (
    .opcode (dec_opcode),
    .ctrl   (dec_ctrl)
  );

  register_file i_register_file (
    .clk         (clk),
    .reset       (reset),
    .read_addr_a (dec_rs),
    .read_addr_b (dec_rt),
    .read_data_a (reg_data_a),
    .read_data_b (reg_data_b),
    .write_en    (mem_wb.valid && mem_wb.reg_write),
    .write_addr  (mem_wb.dst),
    .write_data  (wb_data)
  );

  hazard_unit i_hazard_unit (
    .decode_rs    (dec_rs),
    .decode_rt    (dec_rt),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .mem_wb       (mem_wb),
    .branch_taken (branch_taken),
    .stall        (stall),
    .flush        (flush),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  always_comb begin
    // a stall or flush turns this slot into a bubble
    id_ex_next.valid       = if_id_valid && !stall && !flush;
    id_ex_next.ctrl        = dec_ctrl;
    id_ex_next.rs          = dec_rs;
    id_ex_next.rt          = dec_rt;
    id_ex_next.rd          = dec_rd;
    id_ex_next.read_data_a = reg_data_a;
    id_ex_next.read_data_b = reg_data_b;
    id_ex_next.imm         = if_id_inst[imm_msb:imm_lsb];
  end

  always_ff @(posedge clk) begin
    id_ex <= id_ex_next;
    if (reset) begin
      id_ex.valid <= 1'b0;
    end
  end

  ////////////////////
  // execute
  ////////////////////
  always_comb begin
    case (fwd_a)
      fwd_ex_mem: ex_operand_a = ex_mem.alu_result;
      fwd_mem_wb: ex_operand_a = wb_data;
      default:    ex_operand_a = id_ex.read_data_a;
    endcase
    case (fwd_b)
      fwd_ex_mem: ex_rt_value = ex_mem.alu_result;
      fwd_mem_wb: ex_rt_value = wb_data;
      default:    ex_rt_value = id_ex.read_data_b;
    endcase
  end

  // immediate is zero-extended
  assign ex_operand_b = id_ex.ctrl.alu_src ?
                        {{(data_width-imm_width){1'b0}}, id_ex.imm} : ex_rt_value;

  alu i_alu (
    .alu_op    (id_ex.ctrl.alu_op),
    .operand_a (ex_operand_a),
    .operand_b (ex_operand_b),
    .result    (alu_result),
    .zero      (alu_zero),
    .less      (),
    .greater   ()
  );

  assign branch_taken = id_ex.valid && id_ex.ctrl.branch && alu_zero;

  always_comb begin
    ex_mem_next.valid      = id_ex.valid;
    ex_mem_next.reg_write  = id_ex.ctrl.reg_write;
    ex_mem_next.mem_to_reg = id_ex.ctrl.mem_to_reg;
    ex_mem_next.mem_op     = id_ex.ctrl.mem_op;
    ex_mem_next.dst        = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
    ex_mem_next.alu_result = alu_result;
    ex_mem_next.store_data = ex_rt_value;
  end

  always_ff @(posedge clk) begin
    ex_mem <= ex_mem_next;
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end
  end

  ////////////////////
  // memory
  ////////////////////
  assign address_out    = ex_mem.alu_result[addr_width-1:0];
  assign write_data_out = ex_mem.store_data;
  assign mem_op_out     = ex_mem.valid ? ex_mem.mem_op : mem_none;

  always_comb begin
    mem_wb_next.valid      = ex_mem.valid;
    mem_wb_next.reg_write  = ex_mem.reg_write;
    mem_wb_next.mem_to_reg = ex_mem.mem_to_reg;
    mem_wb_next.dst        = ex_mem.dst;
    mem_wb_next.alu_result = ex_mem.alu_result;
    mem_wb_next.read_data  = read_data;
  end

  always_ff @(posedge clk) begin
    mem_wb <= mem_wb_next;
    if (reset) begin
      mem_wb.valid <= 1'b0;
    end
  end

  // write-back select, also the mem/wb forwarding value
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

endmodule

// ==== processor_asserts.sv ====
`timescale 1ns/100ps

module processor_asserts (
  input logic                           clk,
  input logic                           reset,
  input logic [cpu_pkg::addr_width-1:0] pc,
  input cpu_pkg::mem_op_e               mem_op_out,
  input logic                           stall,
  input logic                           branch_taken,
  input logic [cpu_pkg::addr_width-1:0] branch_target
);

  import cpu_pkg::*;

  logic reset_held;

  // ex/mem valid is only cleared by the first reset edge
  always_ff @(posedge clk) begin
    reset_held <= reset;
  end

  a_quiet_in_reset: assert property (@(posedge clk)
    (reset && reset_held) |-> (mem_op_out == mem_none))
    else $error("memory access while reset is high");

  // taken branch has priority over a stall
  a_stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
    (stall && !branch_taken) |=> (pc == $past(pc)))
    else $error("pc moved during a load-use stall");

  a_branch_loads_pc: assert property (@(posedge clk) disable iff (reset)
    branch_taken |=> (pc == $past(branch_target)))
    else $error("pc did not take the branch target");

endmodule

bind processor processor_asserts i_asserts (
  .clk           (clk),
  .reset         (reset),
  .pc            (pc),
  .mem_op_out    (mem_op_out),
  .stall         (stall),
  .branch_taken  (branch_taken),
  .branch_target (id_ex.imm[cpu_pkg::addr_width-1:0])
);

// ==== processor_tb.sv ====
`timescale 1ns/100ps

module processor_tb;

  import cpu_pkg::*;

  localparam int image_words   = 1024;
  localparam int mem_words     = 256;
  localparam int dmem_base     = 'h100;
  localparam int exp_base      = 'h200;
  localparam int store_timeout = 1000;
  localparam int drain_cycles  = 20;

  logic                  clk;
  logic                  reset;
  logic [addr_width-1:0] pc;
  logic [inst_width-1:0] instruction;
  logic [addr_width-1:0] address_out;
  logic [data_width-1:0] write_data_out;
  mem_op_e               mem_op_out;
  logic [data_width-1:0] read_data;

  // program, data image and expected stores in one array
  logic [31:0]           image [0:image_words-1];
  logic [inst_width-1:0] imem [0:mem_words-1];
  logic [data_width-1:0] dmem [0:mem_words-1];
  logic [addr_width-1:0] exp_addr [$];
  logic [data_width-1:0] exp_data [$];

  int value_errors;
  int other_errors;
  int store_count;
  int expected_count;
  int reset_strobes;

  processor i_dut (
    .clk            (clk),
    .reset          (reset),
    .pc             (pc),
    .instruction    (instruction),
    .address_out    (address_out),
    .write_data_out (write_data_out),
    .mem_op_out     (mem_op_out),
    .read_data      (read_data)
  );

  always #50 clk = ~clk;

  ////////////////////
  // memory models
  ////////////////////
  // both memories answer in the same cycle, outside the model reads as zero
  assign instruction = (pc[addr_width-1:8] == '0) ? imem[pc[7:0]] : '0;
  assign read_data   = (address_out[addr_width-1:8] == '0) ? dmem[address_out[7:0]] : '0;

  // store strobe is registered, so look at it mid-cycle
  always @(negedge clk) begin
    if (mem_op_out == mem_write) begin
      if (reset) begin
        reset_strobes++;
      end else begin
        check_store(address_out, write_data_out);
        dmem[address_out[7:0]] = write_data_out;
      end
    end
  end

  task automatic load_test_image();
    int i;
    for (i = 0; i < image_words; i++) begin
      image[i] = '0;
    end
    $readmemh("processor_testdata.txt", image);
    for (i = 0; i < mem_words; i++) begin
      imem[i] = image[i];
      dmem[i] = image[dmem_base + i];
    end
    expected_count = int'(image[exp_base]);
    if (expected_count > (image_words - exp_base - 1) / 2) begin
      $display("store count %0d in the test data is out of range", expected_count);
      other_errors++;
      expected_count = 0;
    end
    for (i = 0; i < expected_count; i++) begin
      exp_addr.push_back(image[exp_base + 1 + 2 * i][addr_width-1:0]);
      exp_data.push_back(image[exp_base + 2 + 2 * i]);
    end
  endtask

  task automatic check_store(input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] data);
    string name;
    if (store_count >= expected_count) begin
      $display("unexpected store of %h to address %h after the last expected store",
               data, addr);
      other_errors++;
    end else begin
      name = $sformatf("store_%0d", store_count);
      if (addr !== exp_addr[store_count]) begin
        $display("Fail %s address expected %h actual %h", name, exp_addr[store_count], addr);
        value_errors++;
      end
      if (data !== exp_data[store_count]) begin
        $display("Fail %s data expected %h actual %h", name, exp_data[store_count], data);
        value_errors++;
      end
    end
    store_count++;
  endtask

  task automatic wait_for_stores(input int limit);
    int cycles;
    cycles = 0;
    while (store_count < expected_count && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (store_count < expected_count) begin
      $display("timeout after %0d cycles, only %0d of %0d stores seen",
               cycles, store_count, expected_count);
      other_errors++;
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    value_errors   = 0;
    other_errors   = 0;
    store_count    = 0;
    expected_count = 0;
    reset_strobes  = 0;
    load_test_image();

    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // fetch restarts from address 0
    if (pc !== '0) begin
      $display("Fail reset_pc expected %h actual %h", {addr_width{1'b0}}, pc);
      value_errors++;
    end
    if (reset_strobes != 0) begin
      $display("write strobe seen %0d times while reset was high", reset_strobes);
      other_errors++;
    end

    wait_for_stores(store_timeout);
    // skipped stores would show up here
    repeat (drain_cycles) @(posedge clk);

    $display("errors: %0d value, %0d other, %0d of %0d stores seen",
             value_errors, other_errors, store_count, expected_count);
    if (value_errors == 0 && other_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== processor_testdata.txt ====
// program words from 000, initial data memory from 100, store count at 200,
// then the expected stores from 201 as pairs of address and data
@000
// preload r1 = 100 and r2 = 37, then r-type results into r3..r10
18010064 18020025 04221800 08222000 0C222800 10223000
14413800 14224000 08414800 15215000
// addi r11 with immediate ffff
180BFFFF
// store r3..r11 to 10..18
20030010 20040011 20050012 20060013 20070014 20080015
20090016 200A0017 200B0018
// dependent chain at distance 1 and 2
182C0005 05826800 058D7000 200E0019 200D001A
// loads followed directly by their users
1C0F0020 05E18000 2010001B 1C110021 2011001C
// taken beq skips two stores, not-taken beq keeps two
24210021 20010030 20020031 2422003F 2001001D 2002001E
// park in a self loop
24000024
@120
12345678 0BADF00D
@200
0000000F
00000010 00000089
00000011 0000003F
00000012 00000024
00000013 00000065
00000014 00000001
00000015 00000000
00000016 FFFFFFC1
00000017 00000001
00000018 0000FFFF
00000019 000000F7
0000001A 0000008E
0000001B 123456DC
0000001C 0BADF00D
0000001D 00000064
0000001E 00000025

// ==== filelist.f ====
cpu_pkg.sv
program_counter.sv
control_unit.sv
register_file.sv
hazard_unit.sv
alu.sv
processor.sv
processor_asserts.sv
processor_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the processor testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module processor_tb \
  -f filelist.f -o processor_sim || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/processor_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "^ALL CHECKS PASSED$" && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }
